// ==== vlog.f ====
+incdir+hdl
hdl/dma_pkg.sv
hdl/dev_bus_if.sv
hdl/dma_regs.sv
hdl/fdc_emul.sv
hdl/acsi_cmd.sv
hdl/io_port.sv
hdl/dma_top.sv
test/tb_dma.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_dma

all: run

$(SIM): vlog.f $(wildcard hdl/*.sv hdl/*.svh test/*.sv)
	verilator --binary --assert -j 0 --top-module tb_dma -f vlog.f -o Vtb_dma

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "^Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== test/tb_dma.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dma_config.svh"

module tb_dma;

	localparam int PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	// two sync flops plus the edge register
	localparam int ACK_LATENCY = 3;
	localparam int BURST = (1 << `DMA_FIFO_ADDR_BITS) / 8;
	// cycle budget per test with margin included
	localparam int REGS_CYCLES = 160;
	localparam int TYPE1_CYCLES = 220;
	localparam int SECTOR_CYCLES = 220;
	localparam int ACSI_CYCLES = 260;
	localparam int QUEUE_CYCLES = 420;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + REGS_CYCLES + TYPE1_CYCLES
		+ SECTOR_CYCLES + ACSI_CYCLES + QUEUE_CYCLES;

	logic clk;
	logic reset;
	logic [15:0] din;
	logic sel;
	logic [2:0] addr;
	logic lds;
	logic rw;
	logic [15:0] dout;
	logic irq;
	logic br;
	logic fdc_wr_prot;
	logic [4:0] dio_idx;
	logic [7:0] dio_data;
	logic dio_ack;
	logic acsi_valid;
	logic acsi_ready;
	logic [9:0] acsi_data;
	logic drv_side;
	logic [1:0] drv_sel;

	// expected-value model
	logic [4:1] m_mode;
	logic [23:0] m_base;
	logic [7:0] m_scnt;
	logic [7:0] m_track;
	logic [7:0] m_data;
	logic m_dir;
	logic [9:0] exp_q[$];
	bit ready_random;

	int errors;
	int checks;
	int tests_run;
	int tests_failed;
	int test_err0;
	string test_name;

	dma_top u_dma_top (
		.clk         (clk),
		.reset       (reset),
		.din         (din),
		.sel         (sel),
		.addr        (addr),
		.lds         (lds),
		.rw          (rw),
		.dout        (dout),
		.irq         (irq),
		.br          (br),
		.fdc_wr_prot (fdc_wr_prot),
		.dio_idx     (dio_idx),
		.dio_data    (dio_data),
		.dio_ack     (dio_ack),
		.acsi_valid  (acsi_valid),
		.acsi_ready  (acsi_ready),
		.acsi_data   (acsi_data),
		.drv_side    (drv_side),
		.drv_sel     (drv_sel)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	task automatic expect_eq(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		a_value: assert (got === exp)
		else begin
			errors++;
			$display("error: %s is %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic expect_bit(input string name, input logic got, input logic exp);
		expect_eq(name, {15'd0, got}, {15'd0, exp});
	endtask

	task automatic expect_true(input bit ok, input string what);
		checks++;
		a_cond: assert (ok)
		else begin
			errors++;
			$display("failure: %s at %0t", what, $time);
		end
	endtask

	// expected floppy status is motor, wp, track 0 for type I and busy
	function automatic logic [7:0] fdc_status(input logic [7:0] cmd,
		input logic [7:0] track, input logic busy);
		fdc_status = {1'b1, fdc_wr_prot, 3'b000, !cmd[7] && (track == 8'd0), 1'b0, busy};
	endfunction

	// 3 with sectors pending, 1 otherwise
	function automatic logic [15:0] dma_status();
		dma_status = (m_scnt != 8'd0) ? 16'h0003 : 16'h0001;
	endfunction

	// one write cycle with the model updated at the write edge
	task automatic cpu_write(input logic [2:0] a, input logic [15:0] d);
		@(negedge clk);
		sel = 1'b1;
		rw = 1'b0;
		lds = 1'b0;
		addr = a;
		din = d;
		@(posedge clk);
		if (a == 3'h3)
			m_mode = d[4:1];
		if (a == 3'h4)
			m_base[23:16] = d[7:0];
		if (a == 3'h5)
			m_base[15:8] = d[7:0];
		if (a == 3'h6)
			m_base[7:0] = d[7:0];
		if (a == 3'h2 && m_mode[4])
			m_scnt = d[7:0];
		// acsi byte goes to the outbound queue with its select bits
		if (a == 3'h2 && !m_mode[4] && m_mode[3])
			exp_q.push_back({m_mode[2:1], d[7:0]});
		if (a == 3'h2 && !m_mode[4] && !m_mode[3]) begin
			case (m_mode[2:1])
				2'd0: begin
					case (d[7:4])
						4'h0: m_track = 8'd0;
						4'h1: m_track = m_data;
						4'h3: m_track = m_dir ? m_track + 8'd1 : m_track - 8'd1;
						4'h4: m_dir = 1'b1;
						4'h5: begin
							m_dir = 1'b1;
							m_track = m_track + 8'd1;
						end
						4'h6: m_dir = 1'b0;
						4'h7: begin
							m_dir = 1'b0;
							m_track = m_track - 8'd1;
						end
						default: ;
					endcase
				end
				2'd1: m_track = d[7:0];
				2'd3: m_data = d[7:0];
				default: ;
			endcase
		end
		@(negedge clk);
		sel = 1'b0;
		rw = 1'b1;
		lds = 1'b1;
	endtask

	// dout sampled mid low phase and status side effects land at the next edge
	task automatic cpu_read(input logic [2:0] a, output logic [15:0] d);
		@(negedge clk);
		sel = 1'b1;
		rw = 1'b1;
		lds = 1'b0;
		addr = a;
		#(PERIOD / 4);
		d = dout;
		@(negedge clk);
		sel = 1'b0;
		lds = 1'b1;
	endtask

	task automatic read_expect(input logic [2:0] a, input logic [15:0] exp);
		logic [15:0] rd;
		cpu_read(a, rd);
		expect_eq($sformatf("dout at addr %0d", a), rd, exp);
	endtask

	task automatic dio_expect(input logic [4:0] idx, input logic [7:0] exp);
		@(negedge clk);
		dio_idx = idx;
		#(PERIOD / 4);
		expect_eq($sformatf("dio_data at idx %0d", idx), {8'h00, dio_data}, {8'h00, exp});
	endtask

	task automatic set_mode(input logic scnt_sel, input logic acsi_sel, input logic [1:0] rsel);
		cpu_write(3'h3, {11'd0, scnt_sel, acsi_sel, rsel, 1'b0});
	endtask

	task automatic acsi_write(input logic parm, input logic [7:0] b);
		logic [1:0] rsel;
		// upper select bit is ignored by the device but still tagged
		rsel = {1'($urandom), parm};
		set_mode(1'b0, 1'b1, rsel);
		cpu_write(3'h2, {8'h00, b});
	endtask

	task automatic ack_pulse();
		@(negedge clk);
		dio_ack = 1'b1;
		@(negedge clk);
		dio_ack = 1'b0;
		// finished transfer clears the sector count
		m_scnt = 8'd0;
	endtask

	// self-timed command raises irq exactly busy ticks after the write edge
	task automatic timed_cmd(input logic [7:0] cmd);
		set_mode(1'b0, 1'b0, 2'd0);
		cpu_write(3'h2, {8'h00, cmd});
		for (int k = 0; k < `DMA_FDC_BUSY_TICKS; k++) begin
			expect_bit("irq", irq, 1'b0);
			@(negedge clk);
		end
		expect_bit("irq", irq, 1'b1);
		read_expect(3'h2, {8'h00, fdc_status(cmd, m_track, 1'b0)});
		// status read acks the interrupt
		expect_bit("irq", irq, 1'b0);
		set_mode(1'b0, 1'b0, 2'd1);
		read_expect(3'h2, {8'h00, m_track});
		dio_expect(5'd4, cmd);
		dio_expect(5'd5, m_track);
	endtask

	// sector command parked until the io controller acks
	task automatic waiting_cmd(input logic [7:0] cmd);
		int n;
		set_mode(1'b0, 1'b0, 2'd0);
		cpu_write(3'h2, {8'h00, cmd});
		repeat (8) begin
			expect_bit("irq", irq, 1'b0);
			@(negedge clk);
		end
		read_expect(3'h2, {8'h00, fdc_status(cmd, m_track, 1'b1)});
		dio_expect(5'd8, {3'b000, 1'b0, drv_sel, drv_side, 1'b1});
		ack_pulse();
		n = 0;
		while (!irq && n < ACK_LATENCY + 2) begin
			@(negedge clk);
			n++;
		end
		expect_true(irq, $sformatf("no floppy irq within %0d cycles of the ack",
			ACK_LATENCY + 2));
		read_expect(3'h2, {8'h00, fdc_status(cmd, m_track, 1'b0)});
		expect_bit("irq", irq, 1'b0);
	endtask

	task automatic check_registers();
		logic [7:0] s;
		for (int i = 0; i < 4; i++) begin
			cpu_write(3'h4, {8'h00, 8'($urandom)});
			cpu_write(3'h5, {8'h00, 8'($urandom)});
			cpu_write(3'h6, {8'h00, 8'($urandom)});
			read_expect(3'h4, {8'h00, m_base[23:16]});
			read_expect(3'h5, {8'h00, m_base[15:8]});
			read_expect(3'h6, {8'h00, m_base[7:0]});
			// first pass keeps the count at zero
			s = (i == 0) ? 8'h00 : 8'($urandom_range(1, 255));
			set_mode(1'b1, 1'b0, 2'd0);
			cpu_write(3'h2, {8'h00, s});
			read_expect(3'h2, {8'h00, m_scnt});
			read_expect(3'h3, dma_status());
			dio_expect(5'd0, m_base[23:16]);
			dio_expect(5'd1, m_base[15:8]);
			dio_expect(5'd2, m_base[7:0]);
			dio_expect(5'd3, m_scnt);
		end
	endtask

	task automatic run_type1_cmds();
		timed_cmd(8'h00);
		set_mode(1'b0, 1'b0, 2'd3);
		cpu_write(3'h2, {8'h00, 8'($urandom_range(2, 250))});
		timed_cmd(8'h10);
		timed_cmd(8'h50);
		timed_cmd(8'h70);
		// plain step keeps the outward direction
		timed_cmd(8'h30);
		set_mode(1'b0, 1'b0, 2'd3);
		cpu_write(3'h2, 16'h0001);
		timed_cmd(8'h10);
		timed_cmd(8'h70);
		timed_cmd(8'h50);
	endtask

	task automatic run_sector_cmds();
		waiting_cmd(8'h80);
		waiting_cmd(8'ha0);
		@(negedge clk);
		fdc_wr_prot = 1'b1;
		// protected write fails without waiting for data
		timed_cmd(8'ha0);
		@(negedge clk);
		fdc_wr_prot = 1'b0;
	endtask

	task automatic run_acsi_sequence();
		logic [7:0] parms [`DMA_ACSI_PARMS];
		logic [4:0] cmd;
		logic [2:0] tgt;
		int n;
		@(negedge clk);
		drv_sel = 2'($urandom);
		drv_side = 1'($urandom);
		set_mode(1'b1, 1'b0, 2'd0);
		cpu_write(3'h2, {8'h00, 8'($urandom_range(1, 255))});
		cmd = 5'($urandom);
		acsi_write(1'b0, {3'd0, cmd});
		expect_bit("irq", irq, 1'b1);
		read_expect(3'h2, 16'h0000);
		expect_bit("irq", irq, 1'b0);
		for (int i = 0; i < `DMA_ACSI_PARMS; i++) begin
			parms[i] = 8'($urandom);
			acsi_write(1'b1, parms[i]);
			if (i < `DMA_ACSI_PARMS - 1) begin
				expect_bit("irq", irq, 1'b1);
				expect_bit("br", br, 1'b0);
				read_expect(3'h2, 16'h0000);
				expect_bit("irq", irq, 1'b0);
			end else begin
				// last byte starts the transfer
				expect_bit("irq", irq, 1'b0);
				expect_bit("br", br, 1'b1);
			end
		end
		dio_expect(5'd8, {3'b000, 1'b1, drv_sel, drv_side, 1'b0});
		dio_expect(5'd9, {3'd0, cmd});
		for (int i = 0; i < `DMA_ACSI_PARMS; i++)
			dio_expect(5'(10 + i), parms[i]);
		ack_pulse();
		n = 0;
		while (br && n < ACK_LATENCY + 1) begin
			@(negedge clk);
			n++;
		end
		expect_true(!br, "br still high after the ack");
		expect_bit("irq", irq, 1'b1);
		read_expect(3'h2, 16'h0000);
		expect_bit("irq", irq, 1'b0);
		set_mode(1'b1, 1'b0, 2'd0);
		read_expect(3'h2, 16'h0000);
		read_expect(3'h3, dma_status());
		dio_expect(5'd3, 8'h00);
		dio_expect(5'd8, {3'b000, 1'b0, drv_sel, drv_side, 1'b0});

		// other targets stay silent but still capture
		tgt = 3'($urandom_range(1, 7));
		cmd = 5'($urandom);
		acsi_write(1'b0, {tgt, cmd});
		expect_bit("irq", irq, 1'b0);
		for (int i = 0; i < `DMA_ACSI_PARMS; i++) begin
			parms[i] = 8'($urandom);
			acsi_write(1'b1, parms[i]);
			expect_bit("irq", irq, 1'b0);
			expect_bit("br", br, 1'b0);
		end
		read_expect(3'h2, {8'h00, tgt, 5'b00000});
		dio_expect(5'd9, {tgt, cmd});
		for (int i = 0; i < `DMA_ACSI_PARMS; i++)
			dio_expect(5'(10 + i), parms[i]);
	endtask

	task automatic drain_queue();
		int n;
		ready_random = 1'b1;
		n = 0;
		while (exp_q.size() != 0 && n < QUEUE_CYCLES / 2) begin
			@(negedge clk);
			n++;
		end
		expect_true(exp_q.size() == 0, "outbound queue did not drain");
		@(negedge clk);
		expect_bit("acsi_valid", acsi_valid, 1'b0);
	endtask

	task automatic stress_queue();
		drain_queue();
		ready_random = 1'b0;
		for (int i = 0; i < BURST; i++)
			acsi_write(1'($urandom), 8'($urandom));
		// stalled head has to hold
		repeat (10) @(negedge clk);
		expect_bit("acsi_valid", acsi_valid, 1'b1);
		drain_queue();
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_err0 = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == test_err0) begin
			$display("test %0d %s: passed", tests_run, test_name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", tests_run, test_name,
				errors - test_err0);
		end
	endtask

	// queue sink compares the head and then picks ready for the next edge
	initial begin : ready_driver
		bit take;
		forever begin
			@(negedge clk);
			if (!reset) begin
				expect_bit("acsi_valid", acsi_valid, exp_q.size() != 0);
				if (acsi_valid && exp_q.size() != 0)
					expect_eq("acsi_data", {6'd0, acsi_data}, {6'd0, exp_q[0]});
				take = ready_random && ($urandom_range(0, 3) != 0);
				acsi_ready = take;
				if (take && acsi_valid && exp_q.size() != 0)
					void'(exp_q.pop_front());
			end
		end
	end

	a_stall_hold: assert property (@(posedge clk) disable iff (reset)
		acsi_valid && !acsi_ready |=> acsi_valid && $stable(acsi_data))
	else begin
		errors++;
		$display("failure: acsi_data moved while stalled at %0t", $time);
	end

	a_reset_idle: assert property (@(posedge clk) reset |=> !irq && !br && !acsi_valid)
	else begin
		errors++;
		$display("failure: outputs active after a reset edge at %0t", $time);
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * PERIOD);
		$display("timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		void'($urandom(32'hc4c2_6294));
		reset = 1'b1;
		din = 16'h0000;
		sel = 1'b0;
		addr = 3'd0;
		lds = 1'b1;
		rw = 1'b1;
		fdc_wr_prot = 1'b0;
		dio_idx = 5'd0;
		dio_ack = 1'b0;
		acsi_ready = 1'b0;
		drv_side = 1'b0;
		drv_sel = 2'd0;
		m_mode = '0;
		m_base = '0;
		m_scnt = '0;
		m_track = '0;
		m_data = '0;
		m_dir = 1'b0;
		ready_random = 1'b1;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;

		start_test("register readback");
		check_registers();
		end_test();
		start_test("floppy type I");
		run_type1_cmds();
		end_test();
		start_test("floppy sector");
		run_sector_cmds();
		end_test();
		start_test("acsi command");
		run_acsi_sequence();
		end_test();
		start_test("outbound queue");
		stress_queue();
		end_test();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/dma_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_top (
	input  wire        clk,
	input  wire        reset,
	input  wire [15:0] din,
	input  wire        sel,
	input  wire [2:0]  addr,
	input  wire        lds,
	input  wire        rw,
	output logic [15:0] dout,
	output logic       irq,
	output logic       br,
	input  wire        fdc_wr_prot,
	input  wire [4:0]  dio_idx,
	output logic [7:0] dio_data,
	input  wire        dio_ack,
	output logic       acsi_valid,
	input  wire        acsi_ready,
	output logic [9:0] acsi_data,
	input  wire        drv_side,
	input  wire [1:0]  drv_sel
);
	import dma_pkg::*;

	logic q_push;
	acsi_word_t q_word;
	logic [23:0] dma_base;
	logic [7:0] dma_scnt;
	fdc_state_t fdc_state;
	acsi_state_t acsi_state;

	// decoder to controller links
	dev_bus_if fdc_bus ();
	dev_bus_if acsi_bus ();

	dma_regs u_regs (
		.clk      (clk),
		.reset    (reset),
		.din      (din),
		.sel      (sel),
		.addr     (addr),
		.lds      (lds),
		.rw       (rw),
		.dout     (dout),
		.irq      (irq),
		.dio_ack  (dio_ack),
		.dma_base (dma_base),
		.dma_scnt (dma_scnt),
		.fdc      (fdc_bus.host),
		.acsi     (acsi_bus.host),
		.q_push   (q_push),
		.q_word   (q_word)
	);

	fdc_emul u_fdc (
		.clk         (clk),
		.reset       (reset),
		.fdc_wr_prot (fdc_wr_prot),
		.bus         (fdc_bus.dev),
		.state       (fdc_state)
	);

	acsi_cmd u_acsi (
		.clk   (clk),
		.reset (reset),
		.bus   (acsi_bus.dev),
		.br    (br),
		.state (acsi_state)
	);

	io_port u_io (
		.clk        (clk),
		.reset      (reset),
		.q_push     (q_push),
		.q_word     (q_word),
		.acsi_valid (acsi_valid),
		.acsi_ready (acsi_ready),
		.acsi_data  (acsi_data),
		.dio_idx    (dio_idx),
		.dio_data   (dio_data),
		.dma_base   (dma_base),
		.dma_scnt   (dma_scnt),
		.fdc        (fdc_state),
		.acsi       (acsi_state),
		.drv_side   (drv_side),
		.drv_sel    (drv_sel)
	);

endmodule

`default_nettype wire

// ==== hdl/io_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dma_config.svh"

module io_port (
	input  wire                  clk,
	input  wire                  reset,
	input  wire                  q_push,
	input  wire dma_pkg::acsi_word_t  q_word,
	output logic                 acsi_valid,
	input  wire                  acsi_ready,
	output logic [9:0]           acsi_data,
	input  wire [4:0]            dio_idx,
	output logic [7:0]           dio_data,
	input  wire [23:0]           dma_base,
	input  wire [7:0]            dma_scnt,
	input  wire dma_pkg::fdc_state_t  fdc,
	input  wire dma_pkg::acsi_state_t acsi,
	input  wire                  drv_side,
	input  wire [1:0]            drv_sel
);
	import dma_pkg::*;

	localparam int AW = `DMA_FIFO_ADDR_BITS;
	localparam int DEPTH = 1 << AW;
	// first parameter index in the status map
	localparam logic [4:0] PARM_BASE = 5'd10;

	acsi_word_t mem [DEPTH];
	logic [AW-1:0] wptr;
	logic [AW-1:0] rptr;
	logic full;
	logic pop;
	logic [4:0] parm_idx;

	assign acsi_valid = (wptr != rptr);
	assign full = ((wptr + AW'(1)) == rptr);
	assign pop = acsi_valid && acsi_ready;
	assign acsi_data = mem[rptr];

	always_ff @(posedge clk) begin
		if (q_push)
			mem[wptr] <= q_word;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (q_push)
				wptr <= wptr + AW'(1);
			// push into a full queue drops the oldest word
			if (pop || (q_push && full))
				rptr <= rptr + AW'(1);
		end
	end

	// indices below the base wrap to large values
	assign parm_idx = dio_idx - PARM_BASE;

	always_comb begin
		dio_data = 8'h00;
		case (dio_idx)
			5'd0: dio_data = dma_base[23:16];
			5'd1: dio_data = dma_base[15:8];
			5'd2: dio_data = dma_base[7:0];
			5'd3: dio_data = dma_scnt;
			5'd4: dio_data = fdc.cmd;
			5'd5: dio_data = fdc.track;
			5'd6: dio_data = fdc.sector;
			5'd7: dio_data = fdc.data;
			5'd8: dio_data = {3'b000, acsi.busy, drv_sel, drv_side, fdc.busy};
			5'd9: dio_data = {acsi.target, acsi.cmd};
			default: begin
				if (parm_idx < 5'(`DMA_ACSI_PARMS))
					dio_data = acsi.parms[parm_idx];
			end
		endcase
	end

	// stalled head word holds until taken, unless overflow discards it
	a_hold: assert property (@(posedge clk) disable iff (reset)
		(acsi_valid && !acsi_ready && !(q_push && full))
		|=> (acsi_valid && $stable(acsi_data)));

endmodule

`default_nettype wire

// ==== hdl/acsi_cmd.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dma_config.svh"

module acsi_cmd (
	input  wire                  clk,
	input  wire                  reset,
	dev_bus_if.dev               bus,
	output logic                 br,
	output dma_pkg::acsi_state_t state
);
	import dma_pkg::*;

	localparam int PARMS = `DMA_ACSI_PARMS;
	localparam int CNT_W = $clog2(PARMS + 1);
	// counter value meaning all parameters seen
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(PARMS);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(PARMS - 1);

	logic [2:0] target;
	logic [4:0] cmd;
	logic [CNT_W-1:0] cnt;
	logic [PARMS-1:0][7:0] parms;
	logic busy;
	logic irq;
	logic parm_wr;

	// further bytes after the command, extras are ignored
	assign parm_wr = bus.wr && bus.reg_sel[0] && (cnt < CNT_FULL);

	// status is just the target, never busy to the cpu
	assign bus.rdata = {target, 5'b00000};
	assign bus.irq = irq;
	assign state = '{target: target, cmd: cmd, parms: parms, busy: busy};

	always_ff @(posedge clk) begin
		if (parm_wr)
			parms[cnt] <= bus.wdata;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			target <= '0;
			cmd <= '0;
			cnt <= '0;
			busy <= 1'b0;
			br <= 1'b0;
			irq <= 1'b0;
		end else begin
			if (bus.rd_status)
				irq <= 1'b0;
			// io controller done, give the bus back
			if (bus.io_done) begin
				br <= 1'b0;
				if (busy) begin
					irq <= 1'b1;
					busy <= 1'b0;
				end
			end
			if (bus.wr && !bus.reg_sel[0]) begin
				target <= bus.wdata[7:5];
				cmd <= bus.wdata[4:0];
				cnt <= '0;
				// only target 0 answers
				if (bus.wdata[7:5] == 3'd0)
					irq <= 1'b1;
			end
			if (parm_wr) begin
				cnt <= cnt + CNT_W'(1);
				if (target == 3'd0) begin
					// auto-ack until the last byte, which starts the transfer
					if (cnt < CNT_LAST) begin
						irq <= 1'b1;
					end else begin
						br <= 1'b1;
						busy <= 1'b1;
					end
				end
			end
		end
	end

	// bus is only held for a pending transfer
	a_br_busy: assert property (@(posedge clk) disable iff (reset) br |-> busy);

endmodule

`default_nettype wire

// ==== hdl/fdc_emul.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dma_config.svh"

module fdc_emul (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 fdc_wr_prot,
	dev_bus_if.dev              bus,
	output dma_pkg::fdc_state_t state
);
	import dma_pkg::*;

	// 3 parks the counter until the io controller acks
	localparam logic [1:0] BUSY_WAIT = 2'd3;
	localparam logic [1:0] BUSY_LAST = 2'd1;

	logic [7:0] cmd;
	logic [7:0] track;
	logic [7:0] sector;
	logic [7:0] data;
	logic [1:0] busy;
	logic step_dir;
	logic [15:0] motor;
	logic irq;
	logic cmd_wr;
	logic [7:0] status;

	assign cmd_wr = bus.wr && (bus.reg_sel == 2'd0);

	// motor, wp, track 0 for type I only, busy
	assign status = {motor != 16'd0, fdc_wr_prot, 3'b000,
		!cmd[7] && (track == 8'd0), 1'b0, busy != 2'd0};

	always_comb begin
		case (bus.reg_sel)
			2'd0: bus.rdata = status;
			2'd1: bus.rdata = track;
			2'd2: bus.rdata = sector;
			default: bus.rdata = data;
		endcase
	end

	assign bus.irq = irq;
	assign state = '{cmd: cmd, track: track, sector: sector, data: data,
		busy: busy != 2'd0};

	always_ff @(posedge clk) begin
		if (reset) begin
			cmd <= '0;
			track <= '0;
			sector <= '0;
			data <= '0;
			busy <= '0;
			step_dir <= 1'b0;
			motor <= '0;
			irq <= 1'b0;
		end else begin
			// self-timed countdown
			if ((busy != 2'd0) && (busy != BUSY_WAIT))
				busy <= busy - 2'd1;
			// sector data moved by the io controller
			if ((busy == BUSY_WAIT) && bus.io_done)
				busy <= BUSY_LAST;
			if (motor != 16'd0)
				motor <= motor - 16'd1;
			if (bus.rd_status)
				irq <= 1'b0;
			// end of busy phase
			if (busy == BUSY_LAST)
				irq <= 1'b1;

			if (bus.wr) begin
				case (bus.reg_sel)
					2'd0: begin
						cmd <= bus.wdata;
						busy <= 2'(`DMA_FDC_BUSY_TICKS);
						// type I and II spin up the motor
						if (!bus.wdata[7] || (bus.wdata[7:6] == 2'b10))
							motor <= `DMA_MOTOR_TICKS;
						case (bus.wdata[7:4])
							// restore
							4'b0000: track <= 8'd0;
							// seek to data register
							4'b0001: track <= data;
							// step, keeps last direction
							4'b0011: track <= step_dir ? track + 8'd1 : track - 8'd1;
							4'b0100: step_dir <= 1'b1;
							4'b0101: begin
								step_dir <= 1'b1;
								track <= track + 8'd1;
							end
							4'b0110: step_dir <= 1'b0;
							4'b0111: begin
								step_dir <= 1'b0;
								track <= track - 8'd1;
							end
							// read sector waits for data
							4'b1000, 4'b1001: busy <= BUSY_WAIT;
							// write sector, fails fast if protected
							4'b1010, 4'b1011: if (!fdc_wr_prot) busy <= BUSY_WAIT;
							// force interrupt
							4'b1101: busy <= BUSY_LAST;
							default: ;
						endcase
					end
					2'd1: track <= bus.wdata;
					2'd2: sector <= bus.wdata;
					default: data <= bus.wdata;
				endcase
			end
		end
	end

	// waiting only ends on io_done or a fresh command
	a_wait_hold: assert property (@(posedge clk) disable iff (reset)
		(busy == BUSY_WAIT && !bus.io_done && !cmd_wr) |=> (busy == BUSY_WAIT));

endmodule

`default_nettype wire

// ==== hdl/dma_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_regs (
	input  wire                 clk,
	input  wire                 reset,
	input  wire [15:0]          din,
	input  wire                 sel,
	input  wire [2:0]           addr,
	input  wire                 lds,
	input  wire                 rw,
	output logic [15:0]         dout,
	output logic                irq,
	input  wire                 dio_ack,
	output logic [23:0]         dma_base,
	output logic [7:0]          dma_scnt,
	dev_bus_if.host             fdc,
	dev_bus_if.host             acsi,
	output logic                q_push,
	output dma_pkg::acsi_word_t q_word
);
	import dma_pkg::*;

	// bit 0 of the mode word has no function
	logic [4:1] mode;
	logic [23:0] base;
	logic [7:0] scnt;
	// two sync flops plus the edge register
	logic [2:0] ack_sh;
	logic io_done;
	logic wr_cycle;
	logic rd_cycle;
	logic dev_access;
	logic [15:0] dma_status;

	assign wr_cycle = sel && !rw;
	assign rd_cycle = sel && rw;
	// controller window is addr 2 with mode bit 4 clear
	assign dev_access = (addr == 3'h2) && !mode[4];

	// mode bit 3 picks floppy or acsi and bits 2..1 the register
	assign fdc.wr = wr_cycle && !lds && dev_access && !mode[3];
	assign acsi.wr = wr_cycle && !lds && dev_access && mode[3];
	assign fdc.reg_sel = mode[2:1];
	assign acsi.reg_sel = mode[2:1];
	assign fdc.wdata = din[7:0];
	assign acsi.wdata = din[7:0];

	// only register 0 is the floppy status
	assign fdc.rd_status = rd_cycle && dev_access && !mode[3] && (mode[2:1] == 2'b00);
	// any acsi read returns status
	assign acsi.rd_status = rd_cycle && dev_access && mode[3];

	// rising edge of the synchronized ack
	assign io_done = ack_sh[1] && !ack_sh[2];
	assign fdc.io_done = io_done;
	assign acsi.io_done = io_done;

	// every acsi byte goes out to the io controller
	assign q_push = acsi.wr;
	assign q_word = {mode[2:1], din[7:0]};

	assign irq = fdc.irq || acsi.irq;
	assign dma_base = base;
	assign dma_scnt = scnt;

	// bit 0 is dma ok and bit 1 sectors pending
	assign dma_status = {14'd0, scnt != 8'd0, 1'b1};

	always_ff @(posedge clk) begin
		if (reset) begin
			mode <= '0;
			base <= '0;
			scnt <= '0;
			ack_sh <= '0;
		end else begin
			ack_sh <= {ack_sh[1:0], dio_ack};
			// transfer finished so nothing left
			if (io_done)
				scnt <= '0;
			if (wr_cycle) begin
				// mode is a full word write
				if (addr == 3'h3)
					mode <= din[4:1];
				if (!lds) begin
					case (addr)
						3'h2: if (mode[4]) scnt <= din[7:0];
						3'h4: base[23:16] <= din[7:0];
						3'h5: base[15:8] <= din[7:0];
						3'h6: base[7:0] <= din[7:0];
						default: ;
					endcase
				end
			end
		end
	end

	// cpu read mux answers in the same cycle
	always_comb begin
		dout = 16'h0000;
		if (rd_cycle) begin
			case (addr)
				3'h2: begin
					if (mode[4])
						dout = {8'h00, scnt};
					else if (mode[3])
						dout = {8'h00, acsi.rdata};
					else
						dout = {8'h00, fdc.rdata};
				end
				3'h3: dout = dma_status;
				3'h4: dout = {8'h00, base[23:16]};
				3'h5: dout = {8'h00, base[15:8]};
				3'h6: dout = {8'h00, base[7:0]};
				default: dout = 16'h0000;
			endcase
		end
	end

	// sector count only moves on a count write or a finished transfer
	a_scnt_hold: assert property (@(posedge clk) disable iff (reset)
		(!io_done && !(wr_cycle && !lds && (addr == 3'h2) && mode[4])) |=> $stable(scnt));

endmodule

`default_nettype wire

// ==== hdl/dev_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dev_bus_if;
	import dma_pkg::*;

	// strobes from the decoder, all single cycle
	logic wr;
	reg_sel_t reg_sel;
	logic [7:0] wdata;
	logic rd_status;
	logic io_done;

	// device side, rdata follows reg_sel without a clock
	logic irq;
	logic [7:0] rdata;

	modport host (
		output wr,
		output reg_sel,
		output wdata,
		output rd_status,
		output io_done,
		input  irq,
		input  rdata
	);

	modport dev (
		input  wr,
		input  reg_sel,
		input  wdata,
		input  rd_status,
		input  io_done,
		output irq,
		output rdata
	);

endinterface

`default_nettype wire

// ==== hdl/dma_pkg.sv ====
`default_nettype none

`include "dma_config.svh"

package dma_pkg;

	// register index inside one controller
	typedef logic [1:0] reg_sel_t;

	// floppy register file as seen by the io controller
	typedef struct packed {
		logic [7:0] cmd;
		logic [7:0] track;
		logic [7:0] sector;
		logic [7:0] data;
		logic busy;
	} fdc_state_t;

	// captured acsi command block
	typedef struct packed {
		logic [2:0] target;
		logic [4:0] cmd;
		logic [`DMA_ACSI_PARMS-1:0][7:0] parms;
		logic busy;
	} acsi_state_t;

	// queue word, select bits on top of the data byte
	typedef struct packed {
		reg_sel_t sel;
		logic [7:0] data;
	} acsi_word_t;

endpackage

`default_nettype wire

// ==== hdl/dma_config.svh ====
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// outbound queue address width, 256 entries
`define DMA_FIFO_ADDR_BITS 8

// motor keeps spinning this many cycles after a type I/II command
`define DMA_MOTOR_TICKS 16'hffff

// start value of the floppy busy counter for self-timed commands
`define DMA_FDC_BUSY_TICKS 2

// parameter bytes following the acsi command byte
`define DMA_ACSI_PARMS 5

`endif
